//--- hdl/rp_analog_pkg.sv
package rp_analog_pkg;

  //////////////////////
  // widths and counts
  //////////////////////

  localparam int NUM_CHANNELS = 2;   // fixed by the two-phase interleave
  localparam int ADC_PIN_BITS = 16;  // raw word at the ADC pins
  localparam int DAC_BITS     = 14;  // DAC converter resolution

  //////////////////////
  // sample types
  //////////////////////

  // plain two's complement DAC sample
  typedef logic signed [DAC_BITS-1:0] dac_sample_t;

  // one DAC word, read two ways
  //   smp  whole signed value for sum and loopback math
  //   fld  sign bit and magnitude bits for slope inversion
  typedef union packed {
    dac_sample_t smp;
    struct packed {
      logic                msb;   // kept as is
      logic [DAC_BITS-2:0] rest;  // inverted for neg slope
    } fld;
  } dac_word_u;

  // negative-slope code at the pins
  //   0x0000  -> +full scale
  //   0x1fff  -> about zero
  //   0x3fff  -> -full scale
  // same rule on both the ADC and the DAC side

endpackage

//--- hdl/rp_reset_seq.sv
`timescale 1ns/1ps

module rp_reset_seq #(
  parameter int RST_CYCLES = 64  // length of the post-lock reset window
) (
  input  logic adc_clk,
  input  logic reset_i,
  input  logic pll_locked_i,
  output logic chan_rst_o
);

  localparam int CNT_W = $clog2(RST_CYCLES + 1);

  logic             lock_r;    // lock level, one cycle old
  logic             lock_rise;
  logic [CNT_W-1:0] rst_cnt;   // 0 = idle, 1..RST_CYCLES = window

  //////////////////////
  // lock edge
  //////////////////////

  // previous lock level for the edge detector
  always_ff @(posedge adc_clk) begin
    lock_r <= pll_locked_i;
  end

  assign lock_rise = pll_locked_i & ~lock_r;

  //////////////////////
  // window counter
  //////////////////////

  always_ff @(posedge adc_clk) begin
    if (reset_i) begin
      rst_cnt <= '0;
    end else if (!pll_locked_i) begin
      rst_cnt <= '0;                           // lost lock aborts the window
    end else if (lock_rise || (rst_cnt != '0)) begin
      if (rst_cnt == CNT_W'(RST_CYCLES))
        rst_cnt <= '0;                         // window done
      else
        rst_cnt <= rst_cnt + 1'b1;
    end
  end

  // registered so reset_i shows one cycle late
  always_ff @(posedge adc_clk) begin
    chan_rst_o <= reset_i | (rst_cnt != '0);
  end

endmodule

//--- hdl/rp_adc_capture.sv
`timescale 1ns/1ps

module rp_adc_capture #(
  parameter int ADC_BITS = 14  // significant bits taken from each pin word
) (
  input  logic                       adc_clk,
  input  logic                       chan_rst_i,
  input  logic [rp_analog_pkg::NUM_CHANNELS-1:0][rp_analog_pkg::ADC_PIN_BITS-1:0] adc_dat_i,
  output logic signed [ADC_BITS-1:0] adc_smp_o [rp_analog_pkg::NUM_CHANNELS]
);

  import rp_analog_pkg::*;

  logic [ADC_BITS-1:0] adc_raw [NUM_CHANNELS];  // top bits of each pin word

  // a 14 bit part leaves the two lsb pins unused
  always_comb begin
    for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
      adc_raw[ch] = adc_dat_i[ch][ADC_PIN_BITS-1 -: ADC_BITS];
    end
  end

  //////////////////////
  // io register stage
  //////////////////////

  // neg slope to two's complement by keeping msb and flipping the rest
  always_ff @(posedge adc_clk) begin
    for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
      if (chan_rst_i)
        adc_smp_o[ch] <= '0;
      else
        adc_smp_o[ch] <= {adc_raw[ch][ADC_BITS-1], ~adc_raw[ch][ADC_BITS-2:0]};
    end
  end

endmodule

//--- hdl/rp_analog_channel.sv
`timescale 1ns/1ps

module rp_analog_channel #(
  parameter int ADC_BITS = 14  // acquired sample width of 14 or 16
) (
  input  logic                       adc_clk,
  input  logic                       chan_rst_i,
  input  logic signed [ADC_BITS-1:0] adc_smp_i,   // from capture
  input  rp_analog_pkg::dac_sample_t gen_dat_i,   // generator sample
  input  rp_analog_pkg::dac_sample_t ctrl_dat_i,  // controller sample
  input  logic                       loop_adc_i,  // acquire the DAC value
  input  logic                       loop_dac_i,  // send acquired data to DAC
  output logic signed [ADC_BITS-1:0] adc_dat_o,
  output rp_analog_pkg::dac_word_u   dac_word_o
);

  import rp_analog_pkg::*;

  logic signed [DAC_BITS:0] dac_sum;   // one guard bit
  logic                     sum_ovf;   // top two bits disagree
  dac_word_u                dac_sat;   // clamped to DAC range
  dac_word_u                dac_src;   // value going to the encoder

  //////////////////////
  // saturating sum
  //////////////////////

  assign dac_sum = gen_dat_i + ctrl_dat_i;  // both sign-extended
  assign sum_ovf = dac_sum[DAC_BITS] ^ dac_sum[DAC_BITS-1];

  // on overflow the guard bit gives the direction
  always_comb begin
    if (sum_ovf)
      dac_sat.smp = {dac_sum[DAC_BITS], {(DAC_BITS-1){~dac_sum[DAC_BITS]}}};
    else
      dac_sat.smp = dac_sum[DAC_BITS-1:0];
  end

  //////////////////////
  // acquisition side
  //////////////////////

  // size cast of a signed value sign-extends for 16 bit parts
  always_ff @(posedge adc_clk) begin
    if (chan_rst_i)
      adc_dat_o <= '0;
    else if (loop_adc_i)
      adc_dat_o <= ADC_BITS'(dac_sat.smp);  // digital loop on the ADC side
    else
      adc_dat_o <= adc_smp_i;
  end

  //////////////////////
  // DAC side
  //////////////////////

  // loopback takes the top DAC_BITS and drops extra lsbs of a wide ADC
  always_comb begin
    if (loop_dac_i)
      dac_src.smp = adc_dat_o[ADC_BITS-1 -: DAC_BITS];
    else
      dac_src = dac_sat;
  end

  // two's complement to neg slope code
  always_ff @(posedge adc_clk) begin
    if (chan_rst_i) begin
      dac_word_o <= '0;
    end else begin
      dac_word_o.fld.msb  <= dac_src.fld.msb;
      dac_word_o.fld.rest <= ~dac_src.fld.rest;
    end
  end

endmodule

//--- hdl/rp_dac_interleave.sv
`timescale 1ns/1ps

module rp_dac_interleave (
  input  logic                     adc_clk,
  input  logic                     chan_rst_i,
  input  rp_analog_pkg::dac_word_u [rp_analog_pkg::NUM_CHANNELS-1:0] dac_word_i,
  output rp_analog_pkg::dac_word_u dac_dat_o,  // shared DAC data bus
  output logic                     dac_sel_o   // high = channel 0 on the bus
);

  //////////////////////
  // channel select
  //////////////////////

  // free running two-phase toggle parked low in reset
  always_ff @(posedge adc_clk) begin
    if (chan_rst_i)
      dac_sel_o <= 1'b0;
    else
      dac_sel_o <= ~dac_sel_o;
  end

  //////////////////////
  // data bus
  //////////////////////

  // the word goes out together with the next select phase
  //   sel now 0 -> next phase high -> channel 0
  //   sel now 1 -> next phase low  -> channel 1
  // so the current select is the channel index itself
  always_ff @(posedge adc_clk) begin
    if (chan_rst_i)
      dac_dat_o <= '0;                      // quiet bus during reset
    else
      dac_dat_o <= dac_word_i[dac_sel_o];
  end

  // single-rate stand-in for a DDR output pair
  // each channel word is held for one adc_clk period
  // so the pin rate per channel is half of adc_clk

endmodule

//--- hdl/rp_analog_top.sv
`timescale 1ns/1ps

module rp_analog_top #(
  parameter int ADC_BITS   = 14,  // 16 for the wide ADC variant
  parameter int RST_CYCLES = 64   // reset window after PLL lock
) (
  input  logic                       adc_clk,
  input  logic                       reset_i,
  // ADC pins
  input  logic [rp_analog_pkg::NUM_CHANNELS-1:0][rp_analog_pkg::ADC_PIN_BITS-1:0] adc_dat_i,
  // DAC sources
  input  rp_analog_pkg::dac_sample_t [rp_analog_pkg::NUM_CHANNELS-1:0] gen_dat_i,
  input  rp_analog_pkg::dac_sample_t [rp_analog_pkg::NUM_CHANNELS-1:0] ctrl_dat_i,
  // loop levels
  input  logic                       loop_adc_i,
  input  logic                       loop_dac_i,
  input  logic                       pll_locked_i,
  // acquired data
  output logic signed [ADC_BITS-1:0] adc_dat_o [rp_analog_pkg::NUM_CHANNELS],
  // DAC pins
  output rp_analog_pkg::dac_word_u   dac_dat_o,
  output logic                       dac_sel_o,
  output logic                       dac_rst_o
);

  import rp_analog_pkg::*;

  logic                       chan_rst;                 // shared front end reset
  logic signed [ADC_BITS-1:0] adc_smp [NUM_CHANNELS];   // captured samples
  dac_word_u [NUM_CHANNELS-1:0] dac_word;               // encoded per channel

  assign dac_rst_o = chan_rst;

  //////////////////////
  // reset
  //////////////////////

  rp_reset_seq #(
    .RST_CYCLES (RST_CYCLES)
  ) rst_seq_i (
    .adc_clk      (adc_clk     ),
    .reset_i      (reset_i     ),
    .pll_locked_i (pll_locked_i),
    .chan_rst_o   (chan_rst    )
  );

  //////////////////////
  // data path
  //////////////////////

  rp_adc_capture #(
    .ADC_BITS (ADC_BITS)
  ) adc_cap_i (
    .adc_clk    (adc_clk  ),
    .chan_rst_i (chan_rst ),
    .adc_dat_i  (adc_dat_i),
    .adc_smp_o  (adc_smp  )
  );

  for (genvar ch = 0; ch < NUM_CHANNELS; ch++) begin : g_chan
    rp_analog_channel #(
      .ADC_BITS (ADC_BITS)
    ) chan_i (
      .adc_clk    (adc_clk        ),
      .chan_rst_i (chan_rst       ),
      .adc_smp_i  (adc_smp[ch]    ),
      .gen_dat_i  (gen_dat_i[ch]  ),
      .ctrl_dat_i (ctrl_dat_i[ch] ),
      .loop_adc_i (loop_adc_i     ),  // same level on every channel
      .loop_dac_i (loop_dac_i     ),
      .adc_dat_o  (adc_dat_o[ch]  ),
      .dac_word_o (dac_word[ch]   )
    );
  end

  rp_dac_interleave dac_ilv_i (
    .adc_clk    (adc_clk  ),
    .chan_rst_i (chan_rst ),
    .dac_word_i (dac_word ),
    .dac_dat_o  (dac_dat_o),
    .dac_sel_o  (dac_sel_o)
  );

endmodule

//--- verif/rp_analog_clkgen.sv
`timescale 1ns/1ps

module rp_analog_clkgen #(
  parameter int PERIOD_NS    = 40,  // adc_clk period
  parameter int RESET_CYCLES = 3    // posedges with reset held high
) (
  output logic adc_clk,
  output logic reset_o
);

  initial begin
    adc_clk = 1'b0;
    forever #(PERIOD_NS / 2) adc_clk = ~adc_clk;
  end

  // release on a falling edge away from the sampling edge
  initial begin
    reset_o = 1'b1;
    repeat (RESET_CYCLES) @(posedge adc_clk);
    @(negedge adc_clk);
    reset_o = 1'b0;
  end

endmodule

//--- verif/rp_analog_props.sv
`timescale 1ns/1ps

module rp_analog_props (
  input logic                     adc_clk,
  input logic                     chan_rst_i,
  input rp_analog_pkg::dac_word_u [rp_analog_pkg::NUM_CHANNELS-1:0] dac_word_i,
  input rp_analog_pkg::dac_word_u dac_dat_o,
  input logic                     dac_sel_o
);

  logic past_ok = 1'b0;  // one edge of history seen
  logic sel_bad = 1'b0;  // sticky flag for each property
  logic rst_bad = 1'b0;
  logic dat_bad = 1'b0;

  always @(posedge adc_clk) begin
    past_ok <= 1'b1;
  end

  //////////////////////
  // select and reset
  //////////////////////

  sel_toggles: assert property (@(posedge adc_clk)
    past_ok && !$past(chan_rst_i) |-> dac_sel_o != $past(dac_sel_o))
    else begin
      $error("dac_sel_o kept its value outside reset");
      sel_bad = 1'b1;
    end

  // outputs lag chan_rst_i by one register
  quiet_in_reset: assert property (@(posedge adc_clk)
    past_ok && $past(chan_rst_i) |-> !dac_sel_o && dac_dat_o.smp == '0)
    else begin
      $error("DAC bus or select not zero during reset");
      rst_bad = 1'b1;
    end

  //////////////////////
  // data bus
  //////////////////////

  // select high carries channel 0, select low channel 1
  bus_follows_sel: assert property (@(posedge adc_clk)
    past_ok && !$past(chan_rst_i)
      |-> dac_dat_o == (dac_sel_o ? $past(dac_word_i[0]) : $past(dac_word_i[1])))
    else begin
      $error("dac_dat_o does not carry the word of the channel named by dac_sel_o");
      dat_bad = 1'b1;
    end

endmodule

//--- verif/rp_analog_tb.sv
`timescale 1ns/1ps

module rp_analog_tb;

  import rp_analog_pkg::*;

  localparam int          ADC_BITS       = 14;  // DUT default
  localparam int          RST_CYCLES     = 64;  // DUT default
  localparam int          MAX_TESTS      = 32;
  localparam int          HOLD_CYCLES    = 6;
  localparam int          TEST_CYCLES    = 10;  // budget per vector
  localparam int          TIMEOUT_MARGIN = 50;
  localparam logic [31:0] SEED           = 32'h2c27c98f;
  localparam string       TESTS_FILE     = "verif/rp_analog_tests.txt";

  logic                                      adc_clk;
  logic                                      reset_i;
  logic [NUM_CHANNELS-1:0][ADC_PIN_BITS-1:0] adc_dat_i;
  dac_sample_t [NUM_CHANNELS-1:0]            gen_dat_i;
  dac_sample_t [NUM_CHANNELS-1:0]            ctrl_dat_i;
  logic                                      loop_adc_i;
  logic                                      loop_dac_i;
  logic                                      pll_locked_i;
  logic signed [ADC_BITS-1:0]                adc_dat_o [NUM_CHANNELS];
  dac_word_u                                 dac_dat_o;
  logic                                      dac_sel_o;
  logic                                      dac_rst_o;
  logic                                      props_bad;

  // vectors from the tests file
  string                      t_name     [MAX_TESTS];
  logic [ADC_PIN_BITS-1:0]    t_adc      [MAX_TESTS][NUM_CHANNELS];
  dac_sample_t                t_gen      [MAX_TESTS][NUM_CHANNELS];
  dac_sample_t                t_ctrl     [MAX_TESTS][NUM_CHANNELS];
  logic                       t_loop_adc [MAX_TESTS];
  logic                       t_loop_dac [MAX_TESTS];
  logic signed [ADC_BITS-1:0] t_exp_adc  [MAX_TESTS][NUM_CHANNELS];
  dac_word_u                  t_exp_dac  [MAX_TESTS][NUM_CHANNELS];
  int                         num_tests;
  int                         cycle_cnt   = 0;
  int                         cycle_limit = 0;  // 0 until the vectors are loaded

  rp_analog_clkgen #(.PERIOD_NS(40), .RESET_CYCLES(3)) clkgen_i (
    .adc_clk (adc_clk),
    .reset_o (reset_i)
  );

  rp_analog_top dut_i (  // default parameters
    .adc_clk      (adc_clk     ),
    .reset_i      (reset_i     ),
    .adc_dat_i    (adc_dat_i   ),
    .gen_dat_i    (gen_dat_i   ),
    .ctrl_dat_i   (ctrl_dat_i  ),
    .loop_adc_i   (loop_adc_i  ),
    .loop_dac_i   (loop_dac_i  ),
    .pll_locked_i (pll_locked_i),
    .adc_dat_o    (adc_dat_o   ),
    .dac_dat_o    (dac_dat_o   ),
    .dac_sel_o    (dac_sel_o   ),
    .dac_rst_o    (dac_rst_o   )
  );

  bind rp_dac_interleave rp_analog_props props_i (
    .adc_clk    (adc_clk   ),
    .chan_rst_i (chan_rst_i),
    .dac_word_i (dac_word_i),
    .dac_dat_o  (dac_dat_o ),
    .dac_sel_o  (dac_sel_o )
  );

  assign props_bad = dut_i.dac_ilv_i.props_i.sel_bad | dut_i.dac_ilv_i.props_i.rst_bad
                   | dut_i.dac_ilv_i.props_i.dat_bad;

  task automatic abort_run();
    $display("*** TEST FAILED ***");
    $fatal(1, "run stopped at the first error");
  endtask

  //////////////////////
  // checks
  //////////////////////

  task automatic check_adc(input string name, input int ch,
                           input logic signed [ADC_BITS-1:0] exp_v,
                           input logic signed [ADC_BITS-1:0] act_v);
    if (act_v !== exp_v) begin
      $display("FAILED %s adc_dat_o[%0d] expected %h actual %h", name, ch, exp_v, act_v);
      abort_run();
    end
  endtask

  task automatic check_dac(input string name, input string what,
                           input dac_word_u exp_v, input dac_word_u act_v);
    if (act_v !== exp_v) begin
      $display("FAILED %s %s expected %h actual %h", name, what, exp_v.smp, act_v.smp);
      abort_run();
    end
  endtask

  task automatic check_bit(input string name, input string what,
                           input logic exp_v, input logic act_v);
    if (act_v !== exp_v) begin
      $display("FAILED %s %s expected %b actual %b", name, what, exp_v, act_v);
      abort_run();
    end
  endtask

  //////////////////////
  // vectors
  //////////////////////

  task automatic load_tests();
    int          fd;
    int          n;
    string       line;
    string       name_s;
    logic [15:0] a0, a1, g0, g1, c0, c1, e0, e1, d0, d1;
    logic        la, ld;
    fd = $fopen(TESTS_FILE, "r");
    if (fd == 0) begin
      $display("could not open %s for reading", TESTS_FILE);
      abort_run();
    end
    num_tests = 0;
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      if (line.len() < 2 || line[0] == "#") continue;  // blank or comment
      n = $sscanf(line, "%s %h %h %h %h %h %h %b %b %h %h %h %h",
                  name_s, a0, a1, g0, g1, c0, c1, la, ld, e0, e1, d0, d1);
      if (n != 13 || num_tests == MAX_TESTS) begin
        $display("bad or surplus line in the tests file: %s", line);
        abort_run();
      end
      t_name[num_tests]        = name_s;
      t_adc[num_tests][0]      = a0;
      t_adc[num_tests][1]      = a1;
      t_gen[num_tests][0]      = DAC_BITS'(g0);
      t_gen[num_tests][1]      = DAC_BITS'(g1);
      t_ctrl[num_tests][0]     = DAC_BITS'(c0);
      t_ctrl[num_tests][1]     = DAC_BITS'(c1);
      t_loop_adc[num_tests]    = la;
      t_loop_dac[num_tests]    = ld;
      t_exp_adc[num_tests][0]  = ADC_BITS'(e0);
      t_exp_adc[num_tests][1]  = ADC_BITS'(e1);
      t_exp_dac[num_tests][0].smp = DAC_BITS'(d0);
      t_exp_dac[num_tests][1].smp = DAC_BITS'(d1);
      num_tests++;
    end
    $fclose(fd);
  endtask

  // bus carries ch0 while the select is high
  task automatic check_bus_phase(input int i);
    if (dac_sel_o)
      check_dac(t_name[i], "dac_dat_o ch0 phase", t_exp_dac[i][0], dac_dat_o);
    else
      check_dac(t_name[i], "dac_dat_o ch1 phase", t_exp_dac[i][1], dac_dat_o);
  endtask

  task automatic run_vector(input int i);
    logic first_sel;
    int   idle;
    for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
      adc_dat_i[ch]  = t_adc[i][ch];
      gen_dat_i[ch]  = t_gen[i][ch];
      ctrl_dat_i[ch] = t_ctrl[i][ch];
    end
    loop_adc_i = t_loop_adc[i];
    loop_dac_i = t_loop_dac[i];
    repeat (HOLD_CYCLES) @(negedge adc_clk);
    check_adc(t_name[i], 0, t_exp_adc[i][0], adc_dat_o[0]);
    check_adc(t_name[i], 1, t_exp_adc[i][1], adc_dat_o[1]);
    first_sel = dac_sel_o;
    check_bus_phase(i);
    @(negedge adc_clk);
    check_bit(t_name[i], "dac_sel_o", ~first_sel, dac_sel_o);
    check_bus_phase(i);  // other channel now
    idle = int'($urandom % 3);
    repeat (idle) @(negedge adc_clk);
  endtask

  // a rising edge after a lock drop opens the window two cycles later
  task automatic run_lock_window();
    pll_locked_i = 1'b0;
    repeat (3) begin
      @(negedge adc_clk);
      check_bit("lock_reset", "dac_rst_o with lock low", 1'b0, dac_rst_o);
    end
    pll_locked_i = 1'b1;
    @(negedge adc_clk);
    check_bit("lock_reset", "dac_rst_o in edge cycle", 1'b0, dac_rst_o);
    for (int k = 0; k < RST_CYCLES; k++) begin
      @(negedge adc_clk);
      check_bit("lock_reset", "dac_rst_o inside window", 1'b1, dac_rst_o);
      if (k > 0) begin  // outputs clear one register later
        check_adc("lock_reset", 0, '0, adc_dat_o[0]);
        check_adc("lock_reset", 1, '0, adc_dat_o[1]);
        check_dac("lock_reset", "dac_dat_o inside window", '0, dac_dat_o);
        check_bit("lock_reset", "dac_sel_o inside window", 1'b0, dac_sel_o);
      end
    end
    @(negedge adc_clk);
    check_bit("lock_reset", "dac_rst_o after window", 1'b0, dac_rst_o);
  endtask

  //////////////////////
  // watchdogs
  //////////////////////

  always @(posedge adc_clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_limit != 0 && cycle_cnt >= cycle_limit) begin
      $display("timeout, tests still running after %0d cycles", cycle_cnt);
      abort_run();
    end
  end

  always @(negedge adc_clk) begin
    if (props_bad) begin
      $display("an assertion on the DAC interleaver failed");
      abort_run();
    end
  end

  initial begin
    adc_dat_i    = '0;
    gen_dat_i    = '0;
    ctrl_dat_i   = '0;
    loop_adc_i   = 1'b0;
    loop_dac_i   = 1'b0;
    pll_locked_i = 1'b1;  // locked before reset so no window opens
    void'($urandom(SEED));
    load_tests();
    cycle_limit = num_tests * TEST_CYCLES + RST_CYCLES + TIMEOUT_MARGIN;

    repeat (2) @(posedge adc_clk);  // still inside the 3 cycle reset
    @(negedge adc_clk);
    check_bit("reset", "dac_rst_o", 1'b1, dac_rst_o);
    check_bit("reset", "dac_sel_o", 1'b0, dac_sel_o);
    check_dac("reset", "dac_dat_o", '0, dac_dat_o);
    check_adc("reset", 0, '0, adc_dat_o[0]);
    check_adc("reset", 1, '0, adc_dat_o[1]);
    while (dac_rst_o) @(negedge adc_clk);

    for (int i = 0; i < num_tests; i++) begin
      run_vector(i);
    end
    run_lock_window();

    if (props_bad) begin
      $display("an assertion on the DAC interleaver failed");
      abort_run();
    end else begin
      $display("*** TEST PASSED ***");
      $finish;
    end
  end

endmodule

//--- verif/rp_analog_tests.txt
# name adc0 adc1 gen0 gen1 ctrl0 ctrl1 loop_adc loop_dac exp_adc0 exp_adc1 exp_dac0 exp_dac1
# hex words except the two loop bits; dac words are in negative-slope code
adc_mid      7ffc 8000 0000 0000 0000 0000 0 0 0000 3fff 1fff 1fff
adc_full     0000 ffff 0000 0000 0000 0000 0 0 1fff 2000 1fff 1fff
adc_quarter  4000 c003 0000 0000 0000 0000 0 0 0fff 2fff 1fff 1fff
sum_in_range 7ffc 7ffc 0100 3f00 0023 3ff0 0 0 0000 0000 1edc 210f
sum_sat      7ffc 7ffc 1800 2800 1000 3000 0 0 0000 0000 0000 3fff
sum_edge     7ffc 7ffc 2000 1fff 3fff 0000 0 0 0000 0000 3fff 0000
interleave   7ffc 7ffc 0555 0aaa 0000 0000 0 0 0000 0000 1aaa 1555
adc_loop     1234 5678 0100 1800 0023 1000 1 0 0123 1fff 1edc 0000
dac_loop     4000 c003 0100 0200 0023 0000 0 1 0fff 2fff 1000 3000
both_loops   7ffc 7ffc 0555 3f00 0000 3ff0 1 1 0555 3ef0 1aaa 210f

//--- rp_analog_top.f
hdl/rp_analog_pkg.sv
hdl/rp_reset_seq.sv
hdl/rp_adc_capture.sv
hdl/rp_analog_channel.sv
hdl/rp_dac_interleave.sv
hdl/rp_analog_top.sv
verif/rp_analog_clkgen.sv
verif/rp_analog_props.sv
verif/rp_analog_tb.sv

//--- Makefile
# Verilator flow for the analog front end

TOP       ?= rp_analog_tb
FILELIST  ?= rp_analog_top.f
LOG       ?= sim.log
VERILATOR ?= verilator
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
SIM_ARGS  ?= +verilator+error+limit+100
FAIL_MSG  := *** TEST FAILED ***
PASS_MSG  := *** TEST PASSED ***

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qF "$(FAIL_MSG)" $(LOG); then \
	  echo "simulation failed, see $(LOG)"; exit 1; \
	fi
	@if ! grep -qF "$(PASS_MSG)" $(LOG); then \
	  echo "simulation ended without a result, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
